/* Makefile */
# Verilator build and run for the SECDED data path.

VERILATOR ?= verilator
TOP       ?= ecc_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(FILELIST) $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TB PASSED" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/ecc_tb.sv */
`include "ecc_consts.svh"

module ecc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS          = 8;
  localparam int N_CLEAN         = 200;
  localparam int N_SINGLE        = `ECC_TBITS;
  localparam int N_DOUBLE        = 100;
  localparam int N_BP            = `ECC_FIFO_DEPTH + `ECC_OUT_DEPTH + 1; // most words before stall.
  localparam int N_RANDOM        = 300;
  localparam int N_WORDS         = N_CLEAN + N_SINGLE + N_DOUBLE + N_BP + N_RANDOM;
  localparam int WATCHDOG_CYCLES = N_WORDS * 20 + 500;

  logic                 clk = 1'b0;
  logic                 i_rst_n;
  logic                 i_wr_valid;
  ecc_pkg::data_t       i_wr_data;
  ecc_pkg::codeword_t   i_wr_err_mask;
  logic                 o_wr_ready;
  logic                 o_rd_valid;
  ecc_pkg::data_t       o_rd_data;
  ecc_pkg::ecc_status_e o_rd_status;
  logic                 i_rd_ready;

  logic [31:0]          rng = 32'hd36ae17e;
  ecc_pkg::data_t       exp_data_q [$]; // words accepted, oldest first.
  ecc_pkg::codeword_t   exp_mask_q [$];
  string                cur_test = "reset_state";
  logic                 idle_check;
  int                   errors = 0; // monitor side.
  int                   flow_errors = 0; // stimulus side.
  int                   checks = 0;
  int                   n_accepted = 0;
  int                   n_tests = 0;
  int                   err_mark = 0;
  int                   acc_mark = 0;

  ecc_top UUT (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_wr_valid    (i_wr_valid),
    .i_wr_data     (i_wr_data),
    .i_wr_err_mask (i_wr_err_mask),
    .o_wr_ready    (o_wr_ready),
    .o_rd_valid    (o_rd_valid),
    .o_rd_data     (o_rd_data),
    .o_rd_status   (o_rd_status),
    .i_rd_ready    (i_rd_ready)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // ----------------------------------------
  // random source and reference model
  // ----------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw(output logic [31:0] r);
    rng = lcg_next(rng);
    r   = rng;
  endtask

  // up to two distinct flipped positions anywhere in the codeword.
  task automatic draw_mask(input int flips, output ecc_pkg::codeword_t m);
    logic [31:0] r;
    int          p1;
    int          p2;
    m = '0;
    draw(r);
    p1 = int'(r % `ECC_TBITS);
    draw(r);
    p2 = (p1 + 1 + int'(r % (`ECC_TBITS - 1))) % `ECC_TBITS;
    if (flips > 0) m[p1] = 1'b1;
    if (flips > 1) m[p2] = 1'b1;
  endtask

  // the outcome follows from how many bits the mask flips.
  function automatic ecc_pkg::ecc_status_e expected_result(
    input  ecc_pkg::data_t     d,
    input  ecc_pkg::codeword_t m,
    output ecc_pkg::data_t     exp_d,
    output logic               data_known
  );
    int flips;
    flips      = $countones(m);
    exp_d      = d;
    data_known = (flips < 2); // a double error passes data through unrepaired.
    if (flips == 0) return ecc_pkg::ECC_OK;
    else if (flips == 1) return ecc_pkg::ECC_CORRECTED;
    else return ecc_pkg::ECC_UNCORRECTABLE;
  endfunction

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic compare_data(input string name, input ecc_pkg::data_t exp,
                              input ecc_pkg::data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: data expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_status(input string name, input ecc_pkg::ecc_status_e exp,
                                input ecc_pkg::ecc_status_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: status expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // ----------------------------------------
  // scoreboard
  // ----------------------------------------
  always @(posedge clk) begin
    ecc_pkg::data_t       d;
    ecc_pkg::data_t       exp_d;
    ecc_pkg::codeword_t   m;
    ecc_pkg::ecc_status_e exp_s;
    logic                 known;
    if (idle_check) begin
      compare_flag({cur_test, " o_rd_valid"}, 1'b0, o_rd_valid);
      compare_flag({cur_test, " o_wr_ready"}, 1'b1, o_wr_ready);
    end
    if (i_rst_n === 1'b1) begin
      if (i_wr_valid && o_wr_ready) begin
        exp_data_q.push_back(i_wr_data);
        exp_mask_q.push_back(i_wr_err_mask);
        n_accepted++;
      end
      if (o_rd_valid && i_rd_ready) begin
        if (exp_data_q.size() == 0) begin
          errors++;
          $display("%s: a result was read out with no word outstanding", cur_test);
        end else begin
          d     = exp_data_q.pop_front();
          m     = exp_mask_q.pop_front();
          exp_s = expected_result(d, m, exp_d, known);
          compare_status(cur_test, exp_s, o_rd_status);
          if (known) compare_data(cur_test, exp_d, o_rd_data);
        end
      end
    end
  end

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------
  task automatic report_flow(input string msg);
    flow_errors++;
    $display("%s: %s", cur_test, msg);
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_mark = errors + flow_errors;
    acc_mark = n_accepted;
  endtask

  task automatic end_test();
    @(posedge clk);
    while (exp_data_q.size() != 0) @(posedge clk);
    n_tests++;
    $display("test %s done: %0d words, %0d errors", cur_test, n_accepted - acc_mark,
             errors + flow_errors - err_mark);
  endtask

  task automatic write_word(input ecc_pkg::data_t d, input ecc_pkg::codeword_t m);
    i_wr_valid    <= 1'b1;
    i_wr_data     <= d;
    i_wr_err_mask <= m;
    @(posedge clk);
    while (!o_wr_ready) @(posedge clk);
    i_wr_valid <= 1'b0; // overridden by a back to back write.
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    logic [31:0]        r1;
    logic [31:0]        r2;
    ecc_pkg::codeword_t m;
    int                 accepted;
    int                 sent;
    bit                 stalled;
    bit                 pending;
    i_rst_n       <= 1'b0;
    i_wr_valid    <= 1'b0;
    i_wr_data     <= '0;
    i_wr_err_mask <= '0;
    i_rd_ready    <= 1'b0;
    idle_check    <= 1'b0;

    begin_test("reset_state");
    @(posedge clk);
    idle_check <= 1'b1; // registers hold reset values from here on.
    repeat (3) @(posedge clk);
    i_rst_n <= 1'b1;
    @(posedge clk);
    idle_check <= 1'b0;
    i_rd_ready <= 1'b1;
    end_test();

    begin_test("clean_words");
    for (int i = 0; i < N_CLEAN; i++) begin
      draw(r1);
      draw(r2);
      write_word({r1, r2}, '0);
    end
    end_test();

    begin_test("single_bit");
    for (int pos = 0; pos < N_SINGLE; pos++) begin
      draw(r1);
      draw(r2);
      write_word({r1, r2}, ecc_pkg::codeword_t'(1) << pos);
    end
    end_test();

    begin_test("double_bit");
    for (int i = 0; i < N_DOUBLE; i++) begin
      draw(r1);
      draw(r2);
      draw_mask(2, m);
      write_word({r1, r2}, m);
    end
    end_test();

    begin_test("back_pressure");
    i_rd_ready <= 1'b0;
    accepted = 0;
    stalled  = 1'b0;
    draw(r1);
    draw(r2);
    i_wr_valid    <= 1'b1;
    i_wr_data     <= {r1, r2};
    i_wr_err_mask <= '0;
    while (!stalled && accepted < 4 * N_BP) begin
      @(posedge clk);
      if (o_wr_ready) begin
        accepted++;
        draw(r1);
        draw(r2);
        i_wr_data <= {r1, r2};
      end else begin
        stalled = 1'b1;
      end
    end
    i_wr_valid <= 1'b0;
    if (!stalled) begin
      report_flow("o_wr_ready never dropped while reads were held off");
    end else if (accepted > N_BP) begin
      report_flow($sformatf("%0d words taken before o_wr_ready dropped, limit is %0d",
                            accepted, N_BP));
    end
    repeat (20) @(posedge clk);
    i_rd_ready <= 1'b1;
    end_test();

    begin_test("random_flow");
    sent    = 0;
    pending = 1'b0;
    while (sent < N_RANDOM) begin
      draw(r1);
      i_rd_ready <= (r1[9:8] != 2'b00); // ready three cycles in four.
      if (!pending && r1[11:10] != 2'b00) begin
        draw_mask(int'(r1 % 3), m);
        draw(r1);
        draw(r2);
        i_wr_valid    <= 1'b1;
        i_wr_data     <= {r1, r2};
        i_wr_err_mask <= m;
        pending = 1'b1;
      end
      @(posedge clk);
      if (pending && o_wr_ready) begin
        pending = 1'b0;
        sent++;
        i_wr_valid <= 1'b0;
      end
    end
    i_rd_ready <= 1'b1;
    end_test();

    // nothing may come out once every word is accounted for.
    repeat (`ECC_FIFO_DEPTH + `ECC_OUT_DEPTH) @(posedge clk);
    compare_flag({cur_test, " o_rd_valid after drain"}, 1'b0, o_rd_valid);
    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, checks,
             errors + flow_errors);
    if (errors + flow_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  initial begin
    #(WATCHDOG_CYCLES * CLK_NS);
    $display("timeout: run still busy after %0d cycles in %s with %0d words outstanding",
             WATCHDOG_CYCLES, cur_test, exp_data_q.size());
    $display("TB FAILED");
    $finish;
  end

endmodule

/* src/ecc_buffer.sv */
`include "ecc_consts.svh"

module ecc_buffer (
  input  logic               clk,
  input  logic               i_rst_n,
  // from producer
  input  logic               i_valid,
  input  ecc_pkg::codeword_t i_codeword,
  output logic               o_credit,
  // to consumer
  input  logic               i_credit,
  output logic               o_valid,
  output ecc_pkg::codeword_t o_codeword
);

  localparam int AW = $clog2(`ECC_FIFO_DEPTH);

  ecc_pkg::codeword_t    mem [`ECC_FIFO_DEPTH];
  logic [AW-1:0]         wr_ptr;
  logic [AW-1:0]         rd_ptr;
  logic [`ECC_CNT_W-1:0] entries;
  logic [`ECC_CNT_W-1:0] credits;
  logic                  pop;

  // producer credits guarantee room, so every push is taken.
  assign pop = (entries != '0) && (credits != '0);

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (i_valid) begin
      mem[wr_ptr] <= i_codeword;
    end
    if (pop) begin
      o_codeword <= mem[rd_ptr];
    end
  end

  // ----------------------------------------
  // pointers, occupancy and credits
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      entries <= '0;
      credits <= `ECC_CNT_W'(`ECC_OUT_DEPTH);
      o_valid <= 1'b0;
    end else begin
      o_valid <= pop;
      if (i_valid) begin
        wr_ptr <= wr_ptr + 1'b1; // depth is a power of two.
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({i_valid, pop})
        2'b10:   entries <= entries + 1'b1;
        2'b01:   entries <= entries - 1'b1;
        default: entries <= entries;
      endcase
      case ({pop, i_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // a slot frees up as the entry leaves.
  assign o_credit = o_valid;

endmodule

/* src/ecc_consts.svh */
`ifndef ECC_CONSTS_SVH
`define ECC_CONSTS_SVH

// ----------------------------------------
// code geometry
// ----------------------------------------
`define ECC_DBITS 64 // data word.
`define ECC_CBITS 8 // 7 hamming bits and the overall parity.
`define ECC_TBITS 72 // stored codeword.

// ----------------------------------------
// storage and flow control
// ----------------------------------------
`define ECC_FIFO_DEPTH 8 // buffer entries, producer credits at reset.
`define ECC_OUT_DEPTH 2 // result queue entries, buffer credits at reset.
`define ECC_CNT_W 4 // holds 0..ECC_FIFO_DEPTH.

`endif

/* src/ecc_decoder.sv */
`include "ecc_consts.svh"

module ecc_decoder (
  input  logic                 clk,
  input  logic                 i_rst_n,
  // from buffer
  input  logic                 i_valid,
  input  ecc_pkg::codeword_t   i_codeword,
  output logic                 o_credit,
  // read side
  output logic                 o_rd_valid,
  output ecc_pkg::data_t       o_rd_data,
  output ecc_pkg::ecc_status_e o_rd_status,
  input  logic                 i_rd_ready
);

  localparam int QAW = $clog2(`ECC_OUT_DEPTH);

  ecc_pkg::data_t        rx_data;
  ecc_pkg::chk_t         rx_chk;
  logic [`ECC_CBITS-2:0] syn;
  logic                  par_err;
  ecc_pkg::data_t        dec_data;
  ecc_pkg::ecc_status_e  dec_status;

  ecc_pkg::data_t        q_data [`ECC_OUT_DEPTH];
  ecc_pkg::ecc_status_e  q_stat [`ECC_OUT_DEPTH];
  logic [QAW-1:0]        q_wr_ptr;
  logic [QAW-1:0]        q_rd_ptr;
  logic [`ECC_CNT_W-1:0] q_cnt;
  logic                  pop;

  // ----------------------------------------
  // syndrome and correction
  // ----------------------------------------
  assign rx_data = i_codeword[`ECC_TBITS-1:`ECC_CBITS];
  assign rx_chk  = i_codeword[`ECC_CBITS-1:0];
  assign syn     = ecc_pkg::hamming_chk(rx_data) ^ rx_chk[`ECC_CBITS-2:0];
  assign par_err = ^i_codeword; // even overall parity expected.

  always_comb begin
    dec_data   = rx_data;
    dec_status = ecc_pkg::ECC_OK;
    if (par_err) begin
      // odd number of flips, taken as one. zero syndrome is the parity bit itself.
      dec_data   = rx_data ^ ecc_pkg::syn_flip_mask(syn);
      dec_status = ecc_pkg::ECC_CORRECTED;
    end else if (syn != '0) begin
      dec_status = ecc_pkg::ECC_UNCORRECTABLE; // data left as received.
    end
  end

  // ----------------------------------------
  // result queue
  // ----------------------------------------
  assign o_rd_valid  = (q_cnt != '0);
  assign o_rd_data   = q_data[q_rd_ptr];
  assign o_rd_status = q_stat[q_rd_ptr];
  assign pop         = o_rd_valid & i_rd_ready;

  always_ff @(posedge clk) begin
    if (i_valid) begin
      q_data[q_wr_ptr] <= dec_data;
      q_stat[q_wr_ptr] <= dec_status;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      q_wr_ptr <= '0;
      q_rd_ptr <= '0;
      q_cnt    <= '0;
      o_credit <= 1'b0;
    end else begin
      o_credit <= pop; // one pulse per result read out.
      if (i_valid) begin
        q_wr_ptr <= q_wr_ptr + 1'b1;
      end
      if (pop) begin
        q_rd_ptr <= q_rd_ptr + 1'b1;
      end
      case ({i_valid, pop})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: q_cnt <= q_cnt;
      endcase
    end
  end

endmodule

/* src/ecc_encoder.sv */
`include "ecc_consts.svh"

module ecc_encoder (
  input  logic               clk,
  input  logic               i_rst_n,
  // write side
  input  logic               i_wr_valid,
  input  ecc_pkg::data_t     i_wr_data,
  input  ecc_pkg::codeword_t i_wr_err_mask,
  output logic               o_wr_ready,
  // to buffer
  input  logic               i_credit,
  output logic               o_valid,
  output ecc_pkg::codeword_t o_codeword
);

  logic [`ECC_CNT_W-1:0]   credits;
  logic                    send;
  logic [`ECC_CBITS-2:0]   ham;
  ecc_pkg::chk_t           chk;
  ecc_pkg::codeword_t      clean_cw;
  ecc_pkg::codeword_t      stored_cw;

  // ----------------------------------------
  // check bit generation
  // ----------------------------------------
  always_comb begin
    ham       = ecc_pkg::hamming_chk(i_wr_data);
    chk       = {^{i_wr_data, ham}, ham}; // overall parity on top.
    clean_cw  = {i_wr_data, chk};
    stored_cw = clean_cw ^ i_wr_err_mask; // fault injection.
  end

  // ----------------------------------------
  // credit accounting
  // ----------------------------------------
  assign o_wr_ready = (credits != '0);
  assign send       = i_wr_valid & o_wr_ready;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      credits <= `ECC_CNT_W'(`ECC_FIFO_DEPTH);
    end else begin
      case ({send, i_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits; // none, or spend and return together.
      endcase
    end
  end

  // ----------------------------------------
  // output register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= send; // one cycle per codeword.
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      o_codeword <= stored_cw;
    end
  end

endmodule

/* src/ecc_pkg.sv */
`include "ecc_consts.svh"

package ecc_pkg;

  typedef logic [`ECC_DBITS-1:0] data_t;
  typedef logic [`ECC_CBITS-1:0] chk_t;
  typedef logic [`ECC_TBITS-1:0] codeword_t; // {data, chk}.

  typedef enum logic [1:0] {
    ECC_OK,
    ECC_CORRECTED,
    ECC_UNCORRECTABLE
  } ecc_status_e;

  // ----------------------------------------
  // hamming layout helpers
  // ----------------------------------------
  // data bit j sits at the j-th non power of two position in 3..71.
  function automatic logic [`ECC_CBITS-2:0] hamming_chk(data_t d);
    logic [`ECC_CBITS-2:0] c;
    int j;
    c = '0;
    j = 0;
    for (int p = 1; p < `ECC_TBITS; p++) begin
      if ((p & (p - 1)) != 0) begin
        for (int k = 0; k < `ECC_CBITS - 1; k++) begin
          if (p[k]) c[k] ^= d[j];
        end
        j++;
      end
    end
    return c;
  endfunction

  // one-hot data mask for the position a syndrome names, zero for check bits.
  function automatic data_t syn_flip_mask(logic [`ECC_CBITS-2:0] syn);
    data_t m;
    int j;
    m = '0;
    j = 0;
    for (int p = 1; p < `ECC_TBITS; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (p == int'(syn)) m[j] = 1'b1;
        j++;
      end
    end
    return m;
  endfunction

endpackage

/* src/ecc_top.sv */
module ecc_top (
  input  logic                 clk,
  input  logic                 i_rst_n,
  // write side
  input  logic                 i_wr_valid,
  input  ecc_pkg::data_t       i_wr_data,
  input  ecc_pkg::codeword_t   i_wr_err_mask,
  output logic                 o_wr_ready,
  // read side
  output logic                 o_rd_valid,
  output ecc_pkg::data_t       o_rd_data,
  output ecc_pkg::ecc_status_e o_rd_status,
  input  logic                 i_rd_ready
);

  // ----------------------------------------
  // internal credit links
  // ----------------------------------------
  logic               enc_valid;
  ecc_pkg::codeword_t enc_codeword;
  logic               buf_credit; // buffer to producer.
  logic               buf_valid;
  ecc_pkg::codeword_t buf_codeword;
  logic               dec_credit; // consumer to buffer.

  ecc_encoder u_encoder (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_wr_valid    (i_wr_valid),
    .i_wr_data     (i_wr_data),
    .i_wr_err_mask (i_wr_err_mask),
    .o_wr_ready    (o_wr_ready),
    .i_credit      (buf_credit),
    .o_valid       (enc_valid),
    .o_codeword    (enc_codeword)
  );

  ecc_buffer u_buffer (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (enc_valid),
    .i_codeword (enc_codeword),
    .o_credit   (buf_credit),
    .i_credit   (dec_credit),
    .o_valid    (buf_valid),
    .o_codeword (buf_codeword)
  );

  ecc_decoder u_decoder (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (buf_valid),
    .i_codeword  (buf_codeword),
    .o_credit    (dec_credit),
    .o_rd_valid  (o_rd_valid),
    .o_rd_data   (o_rd_data),
    .o_rd_status (o_rd_status),
    .i_rd_ready  (i_rd_ready)
  );

endmodule

/* vlog.f */
+incdir+src
src/ecc_pkg.sv
src/ecc_encoder.sv
src/ecc_buffer.sv
src/ecc_decoder.sv
src/ecc_top.sv
bench/ecc_tb.sv
